//--- rtl/accel_pkg.sv
package accel_pkg;

  //////////////////////////////////////////////////////////////////////
  // Accelerometer register read
  //////////////////////////////////////////////////////////////////////

  // Read register command
  localparam spi_pkg::spi_byte_t CMD_READ   = 8'h0B;
  // Device ID register
  localparam spi_pkg::spi_byte_t DEVID_ADDR = 8'h00;
  localparam spi_pkg::spi_byte_t DUMMY_BYTE = 8'h94; // Clocks the ID back on MISO

  //////////////////////////////////////////////////////////////////////
  // Display
  //////////////////////////////////////////////////////////////////////
  typedef logic [3:0] nibble_t;  // One hex digit
  typedef logic [6:0] seg_t;     // Segments g..a, low lights the segment

  //////////////////////////////////////////////////////////////////////
  // Read sequencer FSM
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [1:0] {
    SEQ_IDLE,     // Waiting for start
    SEQ_SEND,     // Next byte goes out once ready
    SEQ_WAIT,     // One cycle while ready drops
    SEQ_CAPTURE   // Waiting for the byte under the dummy
  } seq_state_t;

endpackage

//--- rtl/device_id_reader.sv
`timescale 1ns/10ps

module device_id_reader (
  input  logic               i_Clk,
  input  logic               i_Rst_L,
  input  logic               i_start,     // Level, read repeats while high
  input  logic               i_miso,
  output spi_pkg::spi_pins_t o_spi,
  output spi_pkg::spi_byte_t o_id_byte,
  output logic               o_id_valid,
  output accel_pkg::seg_t    o_hex_lo,    // Low nibble digit
  output accel_pkg::seg_t    o_hex_hi     // High nibble digit
);
  import spi_pkg::*;

  logic      tx_dv;
  spi_byte_t tx_byte;
  logic      seq_ready;     // Framer gated ready
  logic      engine_ready;
  logic      rx_dv;
  spi_byte_t rx_byte;

  id_read_sequencer seq_i (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_start    (i_start),
    .i_tx_ready (seq_ready),
    .o_tx_dv    (tx_dv),
    .o_tx_byte  (tx_byte),
    .i_rx_dv    (rx_dv),
    .i_rx_byte  (rx_byte),
    .o_id_byte  (o_id_byte),
    .o_id_valid (o_id_valid)
  );

  spi_cs_framer framer_i (
    .i_Clk          (i_Clk),
    .i_Rst_L        (i_Rst_L),
    .i_tx_dv        (tx_dv),
    .i_engine_ready (engine_ready),
    .o_tx_ready     (seq_ready),
    .o_cs_n         (o_spi.cs_n)
  );

  spi_byte_engine engine_i (
    .i_Clk      (i_Clk),
    .i_Rst_L    (i_Rst_L),
    .i_tx_dv    (tx_dv),
    .i_tx_byte  (tx_byte),
    .o_tx_ready (engine_ready),
    .o_rx_dv    (rx_dv),
    .o_rx_byte  (rx_byte),
    .o_sclk     (o_spi.sclk),
    .o_mosi     (o_spi.mosi),
    .i_miso     (i_miso)
  );

  hex_seven_seg hex_lo_i (.i_nibble(o_id_byte[3:0]), .o_seg(o_hex_lo));
  hex_seven_seg hex_hi_i (.i_nibble(o_id_byte[7:4]), .o_seg(o_hex_hi));

endmodule

//--- rtl/hex_seven_seg.sv
`timescale 1ns/10ps

module hex_seven_seg (
  input  accel_pkg::nibble_t i_nibble,
  output accel_pkg::seg_t    o_seg     // Common anode, low is lit
);

  // Bit order g f e d c b a
  always_comb
  begin
    case (i_nibble)
      4'h0:    o_seg = 7'b1000000;
      4'h1:    o_seg = 7'b1111001;
      4'h2:    o_seg = 7'b0100100;
      4'h3:    o_seg = 7'b0110000;
      4'h4:    o_seg = 7'b0011001;
      4'h5:    o_seg = 7'b0010010;
      4'h6:    o_seg = 7'b0000010;
      4'h7:    o_seg = 7'b1111000;
      4'h8:    o_seg = 7'b0000000;
      4'h9:    o_seg = 7'b0010000;
      4'hA:    o_seg = 7'b0001000;
      4'hB:    o_seg = 7'b0000011;  // Lower-case b
      4'hC:    o_seg = 7'b1000110;
      4'hD:    o_seg = 7'b0100001;  // Lower-case d
      4'hE:    o_seg = 7'b0000110;
      default: o_seg = 7'b0001110;  // F
    endcase
  end

endmodule

//--- rtl/id_read_sequencer.sv
`timescale 1ns/10ps

module id_read_sequencer (
  input  logic               i_Clk,
  input  logic               i_Rst_L,
  input  logic               i_start,
  input  logic               i_tx_ready,
  output logic               o_tx_dv,
  output spi_pkg::spi_byte_t o_tx_byte,
  input  logic               i_rx_dv,
  input  spi_pkg::spi_byte_t i_rx_byte,
  output spi_pkg::spi_byte_t o_id_byte,  // Last ID read
  output logic               o_id_valid  // One cycle per finished read
);
  import spi_pkg::*;
  import accel_pkg::*;

  seq_state_t state;
  logic [1:0] byte_idx;    // 0 command, 1 address, 2 dummy
  spi_byte_t  next_byte;

  // Byte for the current slot of the frame
  always_comb
  begin
    case (byte_idx)
      2'd0:    next_byte = CMD_READ;
      2'd1:    next_byte = DEVID_ADDR;
      default: next_byte = DUMMY_BYTE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Read FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      state      <= SEQ_IDLE;
      byte_idx   <= '0;
      o_tx_dv    <= 1'b0;
      o_id_byte  <= '0;    // Both digits show 0
      o_id_valid <= 1'b0;
    end
    else
    begin
      o_tx_dv    <= 1'b0;  // Single-cycle strobes
      o_id_valid <= 1'b0;
      case (state)
        SEQ_IDLE:
        begin
          byte_idx <= '0;
          if (i_start)
            state <= SEQ_SEND;
        end
        SEQ_SEND:
        begin
          if (i_tx_ready)
          begin
            o_tx_dv <= 1'b1;
            if (byte_idx == 2'(BYTES_PER_FRAME - 1))
              state <= SEQ_CAPTURE;  // Dummy is out, ID comes back
            else
              state <= SEQ_WAIT;
          end
        end
        SEQ_WAIT:
        begin
          byte_idx <= byte_idx + 1'b1;
          state    <= SEQ_SEND;
        end
        SEQ_CAPTURE:
        begin
          if (i_rx_dv)
          begin
            o_id_byte  <= i_rx_byte;
            o_id_valid <= 1'b1;
            state      <= SEQ_IDLE;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (state == SEQ_SEND && i_tx_ready)
      o_tx_byte <= next_byte;
  end

endmodule

//--- rtl/spi_byte_engine.sv
`timescale 1ns/10ps

module spi_byte_engine (
  input  logic               i_Clk,
  input  logic               i_Rst_L,
  input  logic               i_tx_dv,     // Byte valid, one cycle
  input  spi_pkg::spi_byte_t i_tx_byte,
  output logic               o_tx_ready,  // High between bytes
  output logic               o_rx_dv,     // Pulses with the eighth sample
  output spi_pkg::spi_byte_t o_rx_byte,
  output logic               o_sclk,
  output logic               o_mosi,
  input  logic               i_miso
);
  import spi_pkg::*;

  half_bit_cnt_t clk_cnt;     // Position inside one SPI clock period
  edge_cnt_t     edges_left;
  logic          sclk_q;      // SPI clock before the alignment flop
  logic          lead_edge;   // Rising edge this cycle
  logic          trail_edge;  // Falling edge this cycle
  logic          tx_dv_q;
  spi_byte_t     tx_byte_q;
  spi_bit_idx_t  tx_bit;
  spi_bit_idx_t  rx_bit;

  //////////////////////////////////////////////////////////////////////
  // SPI clock and edge strobes
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_tx_ready <= 1'b0;
      edges_left <= '0;
      clk_cnt    <= '0;
      sclk_q     <= 1'b0;     // Mode 0 idles low
      lead_edge  <= 1'b0;
      trail_edge <= 1'b0;
    end
    else
    begin
      lead_edge  <= 1'b0;
      trail_edge <= 1'b0;
      if (i_tx_dv)
      begin
        o_tx_ready <= 1'b0;
        edges_left <= edge_cnt_t'(EDGES_PER_BYTE);
      end
      else if (edges_left != '0)
      begin
        o_tx_ready <= 1'b0;
        if (clk_cnt == half_bit_cnt_t'(2 * CLKS_PER_HALF_BIT - 1))
        begin
          edges_left <= edges_left - 1'b1;
          trail_edge <= 1'b1;
          clk_cnt    <= '0;   // Period complete
          sclk_q     <= ~sclk_q;
        end
        else if (clk_cnt == half_bit_cnt_t'(CLKS_PER_HALF_BIT - 1))
        begin
          edges_left <= edges_left - 1'b1;
          lead_edge  <= 1'b1;
          clk_cnt    <= clk_cnt + 1'b1;
          sclk_q     <= ~sclk_q;
        end
        else
          clk_cnt <= clk_cnt + 1'b1;
      end
      else
        o_tx_ready <= 1'b1;   // All 16 edges made
    end
  end

  // Byte held locally while it shifts out
  always_ff @(posedge i_Clk)
  begin
    if (i_tx_dv)
      tx_byte_q <= i_tx_byte;
  end

  //////////////////////////////////////////////////////////////////////
  // MOSI, MSB first, changes on trailing edges
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      tx_dv_q <= 1'b0;
      o_mosi  <= 1'b0;
      tx_bit  <= 3'd7;
    end
    else
    begin
      tx_dv_q <= i_tx_dv;
      if (o_tx_ready)
        tx_bit <= 3'd7;
      else if (tx_dv_q)
      begin
        o_mosi <= tx_byte_q[7]; // First bit must be there before the first rise
        tx_bit <= 3'd6;
      end
      else if (trail_edge)
      begin
        o_mosi <= tx_byte_q[tx_bit];
        tx_bit <= tx_bit - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // MISO, sampled on leading edges
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      o_rx_dv <= 1'b0;
      rx_bit  <= 3'd7;
    end
    else
    begin
      o_rx_dv <= 1'b0;
      if (o_tx_ready)
        rx_bit <= 3'd7;
      else if (lead_edge)
      begin
        rx_bit <= rx_bit - 1'b1;
        if (rx_bit == 3'd0)
          o_rx_dv <= 1'b1;    // Last bit of the byte
      end
    end
  end

  always_ff @(posedge i_Clk)
  begin
    if (lead_edge && !o_tx_ready)
      o_rx_byte[rx_bit] <= i_miso;
  end

  // One flop on the clock so it lines up with MOSI
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
      o_sclk <= 1'b0;
    else
      o_sclk <= sclk_q;
  end

endmodule

//--- rtl/spi_cs_framer.sv
`timescale 1ns/10ps

module spi_cs_framer (
  input  logic i_Clk,
  input  logic i_Rst_L,
  input  logic i_tx_dv,
  input  logic i_engine_ready,  // Byte engine idle
  output logic o_tx_ready,      // Ready as seen by the sequencer
  output logic o_cs_n
);
  import spi_pkg::*;

  typedef enum logic [1:0] {
    CS_IDLE,
    CS_XFER,
    CS_GAP
  } cs_state_t;

  cs_state_t  state;
  logic [1:0] bytes_left;  // Bytes after the current one
  logic [1:0] gap_cnt;

  //////////////////////////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_Clk or negedge i_Rst_L)
  begin
    if (!i_Rst_L)
    begin
      state      <= CS_IDLE;
      o_cs_n     <= 1'b1;
      bytes_left <= '0;
      gap_cnt    <= '0;
    end
    else
    begin
      case (state)
        CS_IDLE:
        begin
          if (i_tx_dv)           // First byte opens the frame
          begin
            bytes_left <= 2'(BYTES_PER_FRAME - 1);
            o_cs_n     <= 1'b0;
            state      <= CS_XFER;
          end
        end
        CS_XFER:
        begin
          if (i_engine_ready)
          begin
            if (bytes_left != '0)
            begin
              if (i_tx_dv)
                bytes_left <= bytes_left - 1'b1;
            end
            else
            begin
              o_cs_n  <= 1'b1;   // Frame done
              gap_cnt <= 2'(CS_INACTIVE_CLKS);
              state   <= CS_GAP;
            end
          end
        end
        CS_GAP:
        begin
          if (gap_cnt != '0)
            gap_cnt <= gap_cnt - 1'b1;
          else
            state <= CS_IDLE;
        end
        default:
        begin
          o_cs_n <= 1'b1;
          state  <= CS_IDLE;
        end
      endcase
    end
  end

  // Ready only in idle or between bytes of the open frame
  assign o_tx_ready = ((state == CS_IDLE) ||
                       (state == CS_XFER && i_engine_ready && bytes_left != '0)) &&
                      !i_tx_dv;

endmodule

//--- rtl/spi_pkg.sv
package spi_pkg;

  //////////////////////////////////////////////////////////////////////
  // SPI link types
  //////////////////////////////////////////////////////////////////////
  typedef logic [7:0] spi_byte_t;      // One byte on MOSI or MISO
  typedef logic [2:0] spi_bit_idx_t;   // Bit position, MSB first
  typedef logic [2:0] half_bit_cnt_t;  // Clocks within one SPI period
  typedef logic [4:0] edge_cnt_t;      // SPI clock edges left in a byte

  // Pins driven toward the accelerometer
  typedef struct packed {
    logic sclk;
    logic mosi;
    logic cs_n;
  } spi_pins_t;

  // Timing, in system clocks
  localparam int CLKS_PER_HALF_BIT = 4;  // Kept small for short runs
  localparam int EDGES_PER_BYTE    = 16; // Two edges per bit
  localparam int BYTES_PER_FRAME   = 3;  // Command, address, dummy
  localparam int CS_INACTIVE_CLKS  = 2;  // Gap after each frame

endpackage

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_device_id_reader

output=$(./obj_dir/Vtb_device_id_reader)
echo "$output"

if echo "$output" | grep -q "Simulation PASSED"; then
  exit 0
fi
exit 1

//--- tb.f
rtl/spi_pkg.sv
rtl/accel_pkg.sv
rtl/spi_byte_engine.sv
rtl/spi_cs_framer.sv
rtl/id_read_sequencer.sv
rtl/hex_seven_seg.sv
rtl/device_id_reader.sv
testbench/tb_clock_gen.sv
testbench/accel_spi_model.sv
testbench/spi_properties.sv
testbench/tb_device_id_reader.sv

//--- testbench/accel_spi_model.sv
`timescale 1ns/10ps

module accel_spi_model (
  input  spi_pkg::spi_pins_t i_spi,
  input  spi_pkg::spi_byte_t i_id,     // ID returned under the dummy byte
  output logic               o_miso
);
  import spi_pkg::*;

  logic      sclk;
  logic      cs_n;
  logic [23:0] tx_frame;                // Bits sent back, MSB first
  spi_byte_t rx_shift;
  spi_byte_t rx_bytes [3];               // MOSI bytes of the last frame
  int        rx_count;
  int        bit_cnt;
  int        frame_cnt;                  // Number of low cs_n frames

  assign sclk = i_spi.sclk;
  assign cs_n = i_spi.cs_n;

  initial
  begin
    o_miso    = 1'b0;
    rx_count  = 0;
    bit_cnt   = 0;
    frame_cnt = 0;
    tx_frame  = '0;
  end

  // New frame, first bit ready before the first rise
  always @(negedge cs_n)
  begin
    tx_frame  = {16'h0000, i_id};
    rx_count  = 0;
    bit_cnt   = 0;
    frame_cnt = frame_cnt + 1;
    o_miso    = tx_frame[23];
  end

  // Mode 0 slave samples MOSI on the rise
  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      rx_shift = {rx_shift[6:0], i_spi.mosi};
      bit_cnt  = bit_cnt + 1;
      if (bit_cnt % 8 == 0 && rx_count < 3)
      begin
        rx_bytes[rx_count] = rx_shift;
        rx_count           = rx_count + 1;
      end
    end
  end

  // Next MISO bit on the fall
  always @(negedge sclk)
  begin
    if (!cs_n && bit_cnt < 24)
      o_miso = tx_frame[23 - bit_cnt];
  end

endmodule

//--- testbench/spi_properties.sv
`timescale 1ns/10ps

module spi_properties (
  input logic i_Clk,
  input logic i_Rst_L,
  input logic i_cs_n,
  input logic i_sclk,
  input logic i_tx_dv,
  input logic i_tx_ready    // Framer ready toward the sequencer
);
  import spi_pkg::*;

  // Gap after each frame
  a_cs_gap: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    $rose(i_cs_n) |-> i_cs_n [* CS_INACTIVE_CLKS + 1])
    else $error("cs_n gap shorter than %0d cycles", CS_INACTIVE_CLKS + 1);

  a_sclk_idle: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_cs_n |-> !i_sclk)
    else $error("sclk high while cs_n is high");

  // Ready seen by the sequencer one cycle before the strobe
  a_dv_ready: assert property (@(posedge i_Clk) disable iff (!i_Rst_L)
    i_tx_dv |-> $past(i_tx_ready))
    else $error("tx_dv issued while tx_ready was low");

endmodule

// Framer ports as seen from the top level
bind device_id_reader spi_properties props_i (
  .i_Clk      (i_Clk),
  .i_Rst_L    (i_Rst_L),
  .i_cs_n     (o_spi.cs_n),
  .i_sclk     (o_spi.sclk),
  .i_tx_dv    (tx_dv),
  .i_tx_ready (seq_ready)
);

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic o_Clk,
  output logic o_Rst_L
);

  initial
  begin
    o_Clk   = 1'b0;
    o_Rst_L = 1'b0;           // Held low for four cycles
    repeat (4) @(posedge o_Clk);
    @(negedge o_Clk);
    o_Rst_L = 1'b1;
  end

  always #5 o_Clk = ~o_Clk;   // 10 ns period

endmodule

//--- testbench/tb_device_id_reader.sv
`timescale 1ns/10ps

module tb_device_id_reader;
  import spi_pkg::*;
  import accel_pkg::*;

  typedef struct packed {
    spi_byte_t id;
    logic      start;     // No pulse means an idle entry
    seg_t      exp_lo;
    seg_t      exp_hi;
  } entry_t;

  localparam int NUM_ENTRIES    = 11;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 400 + 100;

  // Common-anode glyphs, bit order g..a, low is lit
  localparam seg_t GLYPHS [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic      clk;
  logic      rst_l;
  logic      start;
  logic      miso;
  spi_byte_t model_id;
  spi_pins_t spi;
  spi_byte_t id_byte;
  logic      id_valid;
  seg_t      hex_lo;
  seg_t      hex_hi;

  entry_t    table_q [NUM_ENTRIES];
  spi_byte_t ids [NUM_ENTRIES];
  logic      starts [NUM_ENTRIES];
  int        seed;
  int        errors;
  int        fails;
  int        cycles;

  tb_clock_gen clk_i (.o_Clk(clk), .o_Rst_L(rst_l));

  accel_spi_model model_i (.i_spi(spi), .i_id(model_id), .o_miso(miso));

  device_id_reader dut_i (
    .i_Clk      (clk),
    .i_Rst_L    (rst_l),
    .i_start    (start),
    .i_miso     (miso),
    .o_spi      (spi),
    .o_id_byte  (id_byte),
    .o_id_valid (id_valid),
    .o_hex_lo   (hex_lo),
    .o_hex_hi   (hex_hi)
  );

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic check_byte(input spi_byte_t got, input spi_byte_t exp, input string what);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_seg(input seg_t got, input seg_t exp, input string what);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // One read, or an idle wait when no start is given
  task automatic apply_entry(input int idx);
    entry_t e;
    int     frames_before;
    int     errs_before;
    e             = table_q[idx];
    errs_before   = errors;
    frames_before = model_i.frame_cnt;
    model_id      = e.id;
    if (e.start)
    begin
      start = 1'b1;                     // One-cycle pulse
      @(negedge clk);
      start = 1'b0;
      while (!id_valid)
        @(negedge clk);
      check_byte(id_byte, e.id, "o_id_byte");
      check_seg(hex_lo, e.exp_lo, "o_hex_lo");
      check_seg(hex_hi, e.exp_hi, "o_hex_hi");
      check_byte(spi_byte_t'(model_i.frame_cnt - frames_before), 8'd1, "frames per read");
      check_byte(spi_byte_t'(model_i.rx_count), 8'd3, "bytes in frame");
      check_byte(model_i.rx_bytes[0], CMD_READ, "MOSI byte 0");
      check_byte(model_i.rx_bytes[1], DEVID_ADDR, "MOSI byte 1");
      check_byte(model_i.rx_bytes[2], DUMMY_BYTE, "MOSI byte 2");
    end
    else
    begin
      while (spi.cs_n !== 1'b1)         // Last read's frame still closing
        @(negedge clk);
      repeat (300)
      begin
        @(negedge clk);
        check_bit(spi.cs_n, 1'b1, "cs_n while idle");
        check_bit(id_valid, 1'b0, "o_id_valid while idle");
      end
      check_byte(id_byte, e.id, "o_id_byte held");
      check_seg(hex_lo, e.exp_lo, "o_hex_lo held");
      check_seg(hex_hi, e.exp_hi, "o_hex_hi held");
    end
    if (errors == errs_before)
      $display("Test %0d id %h start %b: ok", idx, e.id, e.start);
    else
    begin
      $display("Test %0d id %h start %b: failed", idx, e.id, e.start);
      fails++;
    end
  endtask

  // Watchdog
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial
  begin
    start    = 1'b0;
    model_id = '0;
    errors   = 0;
    fails    = 0;
    cycles   = 0;
    seed     = 32'hd498;
    ids    = '{8'hE5, 8'hE5, 8'h00, 8'h12, 8'h34, 8'h56, 8'h78, 8'h9A, 8'hBC, 8'hDF, 8'h00};
    starts = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
    ids[NUM_ENTRIES-1] = spi_byte_t'($random(seed));
    for (int i = 0; i < NUM_ENTRIES; i++)
      table_q[i] = '{ids[i], starts[i], GLYPHS[ids[i][3:0]], GLYPHS[ids[i][7:4]]};

    // State after reset
    wait (rst_l === 1'b1);
    @(negedge clk);
    check_bit(spi.cs_n, 1'b1, "cs_n after reset");
    check_bit(spi.sclk, 1'b0, "sclk after reset");
    check_bit(id_valid, 1'b0, "o_id_valid after reset");
    check_seg(hex_lo, GLYPHS[0], "o_hex_lo after reset");
    check_seg(hex_hi, GLYPHS[0], "o_hex_hi after reset");
    if (errors != 0)
    begin
      $display("Reset state: failed");
      fails++;
    end
    else
      $display("Reset state: ok");

    for (int i = 0; i < NUM_ENTRIES; i++)
      apply_entry(i);

    $display("Done: %0d tests, %0d failed, %0d checks failed", NUM_ENTRIES + 1, fails, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
